// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := controlUnitTb
FILE_LIST := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "$(PASS_MSG)" $(LOG)

check:
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
	input  controlPkg::stateT     state,
	input  controlPkg::loadSizeT  loadSize,
	input  logic                  zeroFlag,
	input  logic                  lessFlag,
	output logic                  pcWrite,
	output logic                  memWrite,
	output logic                  irWrite,
	output logic                  regWrite,
	output logic                  aWrite,
	output logic                  bWrite,
	output logic                  aluOutLoad,
	output logic                  mdrLoad,
	output logic                  epcWrite,
	output logic                  aluSrcA,
	output controlPkg::aluSrcBT   aluSrcB,
	output controlPkg::aluOpT     aluOp,
	output controlPkg::pcSourceT  pcSource,
	output controlPkg::memToRegT  memToReg,
	output controlPkg::iOrDT      iOrD,
	output controlPkg::regDstT    regDst,
	output controlPkg::epcSelectT epcSelect,
	output controlPkg::loadSizeT  mdrInSize
);

	import controlPkg::*;

	always_comb begin
		pcWrite    = 1'b0;
		memWrite   = 1'b0;
		irWrite    = 1'b0;
		regWrite   = 1'b0;
		aWrite     = 1'b0;
		bWrite     = 1'b0;
		aluOutLoad = 1'b0;
		mdrLoad    = 1'b0;
		epcWrite   = 1'b0;
		aluSrcA    = 1'b0;    // PC on ALU port A
		aluSrcB    = srcBReg;
		aluOp      = aluAdd;
		pcSource   = pcAluResult;
		memToReg   = memAluOut;
		iOrD       = addrPc;
		regDst     = dstRt;
		epcSelect  = epcCapture;
		mdrInSize  = sizeWord;

		case (state)
			Fetch: begin
				aluSrcB    = srcBFour;    // PC + 4
				aluOutLoad = 1'b1;
			end
			F2: begin
				pcWrite  = 1'b1;
				pcSource = pcAluOut;
				irWrite  = 1'b1;    // Instruction word is valid now
			end
			Decode: begin
				aWrite     = 1'b1;
				bWrite     = 1'b1;
				aluSrcB    = srcBImmShift;    // Branch target ahead of time
				aluOutLoad = 1'b1;
			end
			Lui: begin
				regWrite = 1'b1;
				memToReg = memUpperImm;
			end
			Rtype: begin
				aluSrcA    = 1'b1;
				aluOp      = aluFunct;
				aluOutLoad = 1'b1;
			end
			RtypeCont: begin
				regWrite = 1'b1;
				regDst   = dstRd;
			end
			Beq, Bne: begin
				aluSrcA  = 1'b1;
				aluOp    = aluSub;    // rs - rt drives zeroFlag
				pcSource = pcAluOut;
				pcWrite  = (state == Beq) ? zeroFlag : !zeroFlag;
			end
			Load, Sw: begin
				aluSrcA    = 1'b1;
				aluSrcB    = srcBImm;    // Effective address
				aluOutLoad = 1'b1;
				if (state == Load) begin
					mdrInSize = loadSize;
				end
			end
			Load1, Load2: begin
				iOrD = addrAluOut;    // Address held over the memory delay
			end
			Load3: begin
				iOrD    = addrAluOut;
				mdrLoad = 1'b1;
			end
			Load4: begin
				regWrite = 1'b1;
				memToReg = memMdr;
			end
			Sw1: begin
				iOrD     = addrAluOut;
				memWrite = 1'b1;
			end
			Addi1, Xori1: begin
				aluSrcA    = 1'b1;
				aluSrcB    = srcBImm;
				aluOp      = (state == Xori1) ? aluXor : aluAdd;
				aluOutLoad = 1'b1;
			end
			Addi2, Xori2: begin
				regWrite = 1'b1;    // Result to rt
			end
			J: begin
				pcWrite  = 1'b1;
				pcSource = pcJumpTarget;
			end
			Jal: begin
				pcWrite  = 1'b1;
				pcSource = pcJumpTarget;
				regWrite = 1'b1;
				regDst   = dstLink;
			end
			Jr: begin
				aluSrcA = 1'b1;    // rt field is zero, so the ALU passes rs
				pcWrite = 1'b1;
			end
			Slt, Slti: begin
				aluSrcA    = 1'b1;
				aluSrcB    = (state == Slti) ? srcBImm : srcBReg;
				aluOp      = aluSub;
				aluOutLoad = 1'b1;
			end
			SltCont: begin
				regWrite = 1'b1;
				regDst   = dstRd;
				memToReg = lessFlag ? memOne : memZero;
			end
			Ovf, OpExc: begin
				iOrD     = (state == Ovf) ? addrOvf : addrOpExc;
				epcWrite = 1'b1;    // Save the faulting PC
			end
			Ovf1, OpExc1: begin
				iOrD = (state == Ovf1) ? addrOvf : addrOpExc;
			end
			Ovf2, OpExc2: begin
				pcWrite   = 1'b1;
				epcSelect = epcVector;    // Handler address read from memory
			end
			Rte: begin
				pcWrite   = 1'b1;
				epcSelect = epcReturn;
			end
			default: begin
				// F1, F3 and Brk stay idle
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/controlPkg.sv
`default_nettype none

package controlPkg;

	localparam int opWidth = 6;    // Opcode and function field width
	localparam int stateWidth = 6;

	// Primary opcodes
	localparam logic [opWidth-1:0] opRtype = 6'h00;
	localparam logic [opWidth-1:0] opJ     = 6'h02;
	localparam logic [opWidth-1:0] opJal   = 6'h03;
	localparam logic [opWidth-1:0] opBeq   = 6'h04;
	localparam logic [opWidth-1:0] opBne   = 6'h05;
	localparam logic [opWidth-1:0] opAddi  = 6'h08;
	localparam logic [opWidth-1:0] opAddiu = 6'h09;
	localparam logic [opWidth-1:0] opSlti  = 6'h0a;
	localparam logic [opWidth-1:0] opXori  = 6'h0e;
	localparam logic [opWidth-1:0] opLui   = 6'h0f;
	localparam logic [opWidth-1:0] opRte   = 6'h10;
	localparam logic [opWidth-1:0] opLw    = 6'h23;
	localparam logic [opWidth-1:0] opLb    = 6'h24;
	localparam logic [opWidth-1:0] opLh    = 6'h25;
	localparam logic [opWidth-1:0] opSw    = 6'h2b;

	// Function codes under opRtype
	localparam logic [opWidth-1:0] fnJr   = 6'h08;
	localparam logic [opWidth-1:0] fnAddu = 6'h21;
	localparam logic [opWidth-1:0] fnSubu = 6'h23;
	localparam logic [opWidth-1:0] fnSlt  = 6'h2a;

	typedef enum logic [stateWidth-1:0] {
		Fetch, F1, F2, F3, Decode,
		Lui, Rtype, RtypeCont, Beq, Bne,
		Load, Load1, Load2, Load3, Load4,
		Sw, Sw1, J, Brk,
		Addi1, Addi2, Xori1, Xori2,
		Jal, Jr, Slt, Slti, SltCont,
		Ovf, Ovf1, Ovf2,
		OpExc, OpExc1, OpExc2,
		Rte
	} stateT;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluFunct = 3'd2,    // ALU control decodes funct
		aluXor   = 3'd3
	} aluOpT;

	typedef enum logic [1:0] {
		srcBReg      = 2'd0,
		srcBFour     = 2'd1,
		srcBImm      = 2'd2,    // Sign-extended immediate
		srcBImmShift = 2'd3     // Immediate shifted left by two
	} aluSrcBT;

	typedef enum logic [1:0] {
		pcAluResult  = 2'd0,
		pcAluOut     = 2'd1,
		pcJumpTarget = 2'd2
	} pcSourceT;

	typedef enum logic [2:0] {
		memAluOut   = 3'd0,
		memMdr      = 3'd1,
		memUpperImm = 3'd2,
		memZero     = 3'd3,
		memOne      = 3'd4
	} memToRegT;

	typedef enum logic [2:0] {
		addrPc     = 3'd0,
		addrAluOut = 3'd1,
		addrOpExc  = 3'd2,    // Invalid opcode handler vector
		addrOvf    = 3'd3
	} iOrDT;

	typedef enum logic [1:0] {
		dstRt   = 2'd0,
		dstRd   = 2'd1,
		dstLink = 2'd2    // Register 31
	} regDstT;

	typedef enum logic [1:0] {
		epcCapture = 2'd0,
		epcVector  = 2'd1,
		epcReturn  = 2'd2
	} epcSelectT;

	typedef enum logic [1:0] {
		sizeWord = 2'd0,
		sizeHalf = 2'd1,
		sizeByte = 2'd2
	} loadSizeT;

endpackage

`default_nettype wire

// File: logic/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
	input  logic                           Clk,
	input  logic                           Reset,
	input  logic [controlPkg::opWidth-1:0] op,
	input  logic [controlPkg::opWidth-1:0] funct,
	input  logic                           breakReq,
	input  logic                           overflowFlag,
	input  logic                           zeroFlag,
	input  logic                           lessFlag,
	output controlPkg::stateT              state,
	output logic                           pcWrite,
	output logic                           memWrite,
	output logic                           irWrite,
	output logic                           regWrite,
	output logic                           aWrite,
	output logic                           bWrite,
	output logic                           aluOutLoad,
	output logic                           mdrLoad,
	output logic                           epcWrite,
	output logic                           aluSrcA,
	output controlPkg::aluSrcBT            aluSrcB,
	output controlPkg::aluOpT              aluOp,
	output controlPkg::pcSourceT           pcSource,
	output controlPkg::memToRegT           memToReg,
	output controlPkg::iOrDT               iOrD,
	output controlPkg::regDstT             regDst,
	output controlPkg::epcSelectT          epcSelect,
	output controlPkg::loadSizeT           mdrInSize
);

	import controlPkg::*;

	stateT    dispatchState;
	logic     overflowExempt;
	loadSizeT loadSize;    // Latched in Decode

	opcodeDispatch opcodeDispatch_i (
		.Clk            (Clk),
		.Reset          (Reset),
		.op             (op),
		.funct          (funct),
		.state          (state),
		.dispatchState  (dispatchState),
		.overflowExempt (overflowExempt),
		.loadSize       (loadSize)
	);

	stateSequencer stateSequencer_i (
		.Clk            (Clk),
		.Reset          (Reset),
		.breakReq       (breakReq),
		.overflowFlag   (overflowFlag),
		.dispatchState  (dispatchState),
		.overflowExempt (overflowExempt),
		.state          (state)
	);

	controlDecoder controlDecoder_i (
		.state      (state),
		.loadSize   (loadSize),
		.zeroFlag   (zeroFlag),
		.lessFlag   (lessFlag),
		.pcWrite    (pcWrite),
		.memWrite   (memWrite),
		.irWrite    (irWrite),
		.regWrite   (regWrite),
		.aWrite     (aWrite),
		.bWrite     (bWrite),
		.aluOutLoad (aluOutLoad),
		.mdrLoad    (mdrLoad),
		.epcWrite   (epcWrite),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.aluOp      (aluOp),
		.pcSource   (pcSource),
		.memToReg   (memToReg),
		.iOrD       (iOrD),
		.regDst     (regDst),
		.epcSelect  (epcSelect),
		.mdrInSize  (mdrInSize)
	);

endmodule

`default_nettype wire

// File: logic/opcodeDispatch.sv
`timescale 1ns/1ns
`default_nettype none

module opcodeDispatch (
	input  logic                         Clk,
	input  logic                         Reset,
	input  logic [controlPkg::opWidth-1:0] op,
	input  logic [controlPkg::opWidth-1:0] funct,
	input  controlPkg::stateT            state,
	output controlPkg::stateT            dispatchState,
	output logic                         overflowExempt,
	output controlPkg::loadSizeT         loadSize
);

	import controlPkg::*;

	loadSizeT decodedSize;    // Width implied by the current opcode

	// Execution state entered after Decode
	always_comb begin
		case (op)
			opRtype: begin
				case (funct)
					fnJr:    dispatchState = Jr;
					fnSlt:   dispatchState = Slt;
					default: dispatchState = Rtype;    // ALU op picked by funct later
				endcase
			end
			opJ:     dispatchState = J;
			opJal:   dispatchState = Jal;
			opBeq:   dispatchState = Beq;
			opBne:   dispatchState = Bne;
			opAddi:  dispatchState = Addi1;
			opAddiu: dispatchState = Addi1;    // Same path, differs only on overflow
			opSlti:  dispatchState = Slti;
			opXori:  dispatchState = Xori1;
			opLui:   dispatchState = Lui;
			opRte:   dispatchState = Rte;
			opLw:    dispatchState = Load;
			opLb:    dispatchState = Load;
			opLh:    dispatchState = Load;
			opSw:    dispatchState = Sw;
			default: dispatchState = OpExc;    // Unknown opcode traps
		endcase
	end

	always_comb begin
		case (op)
			opLb:    decodedSize = sizeByte;
			opLh:    decodedSize = sizeHalf;
			default: decodedSize = sizeWord;
		endcase
	end

	// Unsigned arithmetic never raises the overflow trap
	assign overflowExempt = ((op == opRtype) && ((funct == fnAddu) || (funct == fnSubu)))
		|| (op == opAddiu);

	// Held for the whole load sequence
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			loadSize <= sizeWord;
		end else if (state == Decode) begin
			loadSize <= decodedSize;
		end
	end

endmodule

`default_nettype wire

// File: logic/stateSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module stateSequencer (
	input  logic              Clk,
	input  logic              Reset,
	input  logic              breakReq,
	input  logic              overflowFlag,
	input  controlPkg::stateT dispatchState,
	input  logic              overflowExempt,
	output controlPkg::stateT state
);

	import controlPkg::*;

	stateT nextState;
	logic  arithState;    // States whose ALU result can overflow
	logic  ovfTrap;

	assign arithState = (state == Rtype) || (state == Addi1);
	assign ovfTrap = arithState && overflowFlag && !overflowExempt;

	always_comb begin
		if (breakReq) begin
			nextState = Brk;    // Break wins over everything but Reset
		end else if (ovfTrap) begin
			nextState = Ovf;
		end else begin
			case (state)
				// Four-cycle fetch and decode
				Fetch:     nextState = F1;
				F1:        nextState = F2;
				F2:        nextState = F3;
				F3:        nextState = Decode;
				Decode:    nextState = dispatchState;

				Rtype:     nextState = RtypeCont;
				RtypeCont: nextState = Fetch;
				Addi1:     nextState = Addi2;
				Addi2:     nextState = Fetch;
				Xori1:     nextState = Xori2;
				Xori2:     nextState = Fetch;
				Slt:       nextState = SltCont;
				Slti:      nextState = SltCont;    // Shares the write-back state
				SltCont:   nextState = Fetch;

				Load:      nextState = Load1;
				Load1:     nextState = Load2;
				Load2:     nextState = Load3;
				Load3:     nextState = Load4;
				Load4:     nextState = Fetch;
				Sw:        nextState = Sw1;
				Sw1:       nextState = Fetch;

				Beq:       nextState = Fetch;
				Bne:       nextState = Fetch;
				J:         nextState = Fetch;
				Jal:       nextState = Fetch;
				Jr:        nextState = Fetch;
				Lui:       nextState = Fetch;
				Rte:       nextState = Fetch;

				// Exception sequences
				Ovf:       nextState = Ovf1;
				Ovf1:      nextState = Ovf2;
				Ovf2:      nextState = Fetch;
				OpExc:     nextState = OpExc1;
				OpExc1:    nextState = OpExc2;
				OpExc2:    nextState = Fetch;

				Brk:       nextState = Brk;    // Only Reset leaves
				default:   nextState = Fetch;
			endcase
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= Fetch;
		end else begin
			state <= nextState;
		end
	end

endmodule

`default_nettype wire

// File: sim.f
logic/controlPkg.sv
logic/opcodeDispatch.sv
logic/stateSequencer.sv
logic/controlDecoder.sv
logic/controlUnit.sv
tests/controlUnit_properties.sv
tests/controlUnitTb.sv

// File: tests/controlUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb;

	import controlPkg::*;

	localparam int cycleLimit = 400;    // Tests need about 210 cycles
	localparam logic [opWidth-1:0] opInvalid = 6'h3f;    // Not in the opcode table
	localparam logic [opWidth-1:0] fnAdd = 6'h20;    // Signed add that can trap

	logic               Clk = 1'b0;
	logic               Reset;
	logic [opWidth-1:0] op;
	logic [opWidth-1:0] funct;
	logic               breakReq;
	logic               overflowFlag;
	logic               zeroFlag;
	logic               lessFlag;
	stateT              state;
	logic               pcWrite;
	logic               memWrite;
	logic               irWrite;
	logic               regWrite;
	logic               aWrite;
	logic               bWrite;
	logic               aluOutLoad;
	logic               mdrLoad;
	logic               epcWrite;
	logic               aluSrcA;
	aluSrcBT            aluSrcB;
	aluOpT              aluOp;
	pcSourceT           pcSource;
	memToRegT           memToReg;
	iOrDT               iOrD;
	regDstT             regDst;
	epcSelectT          epcSelect;
	loadSizeT           mdrInSize;

	integer seed;
	int     cycleCount = 0;
	stateT  prevState = Fetch;
	logic   nextOvf = 1'b0;    // Flags applied with the next instruction
	logic   nextZero = 1'b0;
	logic   nextLess = 1'b0;

	controlUnit controlUnit_i (.*);

	always #50 Clk = ~Clk;

	always @(posedge Clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Something failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic checkValue(input string testName, input string what,
		input int expected, input int actual);
		if (expected != actual) begin
			$display("Mismatch in %s, %s: expected %0d, actual %0d",
				testName, what, expected, actual);
			$display("Something failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Strobe and Brk rules checked between clock edges
	always @(negedge Clk) begin
		if (!Reset) begin
			checkValue("strobeMonitor", "memWrite with regWrite", 0,
				int'(memWrite && regWrite));
			checkValue("strobeMonitor", "irWrite outside F2", 0, int'(irWrite && (state != F2)));
			if (prevState == Brk) begin
				checkValue("strobeMonitor", "state after Brk", int'(Brk), int'(state));
			end
		end
		prevState <= state;
	end

	function automatic logic [opWidth-1:0] randomFunct();
		integer bits;
		bits = $random(seed);
		return bits[opWidth-1:0];    // Don't-care bits of an I-type word
	endfunction

	task automatic checkWritesIdle(input string testName);
		checkValue(testName, "pcWrite", 0, int'(pcWrite));
		checkValue(testName, "memWrite", 0, int'(memWrite));
		checkValue(testName, "regWrite", 0, int'(regWrite));
		checkValue(testName, "irWrite", 0, int'(irWrite));
		checkValue(testName, "epcWrite", 0, int'(epcWrite));
		checkValue(testName, "aWrite", 0, int'(aWrite));
		checkValue(testName, "bWrite", 0, int'(bWrite));
		checkValue(testName, "mdrLoad", 0, int'(mdrLoad));
	endtask

	task automatic expectState(input string testName, input stateT expected);
		@(negedge Clk);
		checkValue(testName, "state", int'(expected), int'(state));
	endtask

	task automatic applyReset(input int cycles);
		@(posedge Clk);
		Reset <= 1'b1;
		repeat (cycles) begin
			@(negedge Clk);
			checkValue("reset", "state", int'(Fetch), int'(state));
			checkWritesIdle("reset");
			@(posedge Clk);
		end
		Reset <= 1'b0;
		@(negedge Clk);
		checkValue("reset", "state after release", int'(Fetch), int'(state));
	endtask

	// Runs Fetch to Decode between falling edges
	task automatic fetchAndDecode(input string testName, input logic [opWidth-1:0] opcode,
		input logic [opWidth-1:0] fn);
		checkValue(testName, "state", int'(Fetch), int'(state));
		checkWritesIdle(testName);
		checkValue(testName, "aluOutLoad in Fetch", 1, int'(aluOutLoad));
		checkValue(testName, "aluSrcA in Fetch", 0, int'(aluSrcA));
		checkValue(testName, "aluSrcB in Fetch", int'(srcBFour), int'(aluSrcB));
		@(posedge Clk);
		op           <= opcode;
		funct        <= fn;
		overflowFlag <= nextOvf;
		zeroFlag     <= nextZero;
		lessFlag     <= nextLess;
		expectState(testName, F1);
		checkValue(testName, "pcWrite in F1", 0, int'(pcWrite));
		checkValue(testName, "irWrite in F1", 0, int'(irWrite));
		expectState(testName, F2);
		checkValue(testName, "pcWrite in F2", 1, int'(pcWrite));
		checkValue(testName, "irWrite in F2", 1, int'(irWrite));
		expectState(testName, F3);
		checkValue(testName, "pcWrite in F3", 0, int'(pcWrite));
		checkValue(testName, "irWrite in F3", 0, int'(irWrite));
		expectState(testName, Decode);
		checkValue(testName, "pcWrite in Decode", 0, int'(pcWrite));
		checkValue(testName, "irWrite in Decode", 0, int'(irWrite));
		checkValue(testName, "aWrite in Decode", 1, int'(aWrite));
		checkValue(testName, "bWrite in Decode", 1, int'(bWrite));
	endtask

	task automatic runInstruction(input string testName, input logic [opWidth-1:0] opcode,
		input logic [opWidth-1:0] fn, input stateT firstState, input int execCycles);
		fetchAndDecode(testName, opcode, fn);
		expectState(testName, firstState);
		repeat (execCycles - 1) begin
			@(negedge Clk);
			checkValue(testName, "still executing", 1, int'(state != Fetch));
		end
		expectState(testName, Fetch);
	endtask

	task automatic testFetchSequence();
		runInstruction("fetchLui", opLui, randomFunct(), Lui, 1);
	endtask

	task automatic testRtype();
		fetchAndDecode("rtypeAdd", opRtype, fnAdd);
		expectState("rtypeAdd", Rtype);
		checkValue("rtypeAdd", "regWrite in Rtype", 0, int'(regWrite));
		checkValue("rtypeAdd", "aluSrcA", 1, int'(aluSrcA));
		checkValue("rtypeAdd", "aluOp", int'(aluFunct), int'(aluOp));
		expectState("rtypeAdd", RtypeCont);
		checkValue("rtypeAdd", "regWrite", 1, int'(regWrite));
		checkValue("rtypeAdd", "regDst", int'(dstRd), int'(regDst));
		expectState("rtypeAdd", Fetch);
	endtask

	task automatic testJumps();
		fetchAndDecode("jump", opJ, randomFunct());
		expectState("jump", J);
		checkValue("jump", "pcWrite", 1, int'(pcWrite));
		checkValue("jump", "pcSource", int'(pcJumpTarget), int'(pcSource));
		checkValue("jump", "regWrite", 0, int'(regWrite));
		expectState("jump", Fetch);
		fetchAndDecode("jal", opJal, randomFunct());
		expectState("jal", Jal);
		checkValue("jal", "pcWrite", 1, int'(pcWrite));
		checkValue("jal", "regWrite", 1, int'(regWrite));
		checkValue("jal", "regDst", int'(dstLink), int'(regDst));
		expectState("jal", Fetch);
		fetchAndDecode("jr", opRtype, fnJr);
		expectState("jr", Jr);
		checkValue("jr", "pcWrite", 1, int'(pcWrite));
		checkValue("jr", "regWrite", 0, int'(regWrite));
		expectState("jr", Fetch);
	endtask

	task automatic immediateCase(input string testName, input logic [opWidth-1:0] opcode,
		input stateT aluState, input stateT writeState, input aluOpT expectedOp);
		fetchAndDecode(testName, opcode, randomFunct());
		expectState(testName, aluState);
		checkValue(testName, "aluSrcB", int'(srcBImm), int'(aluSrcB));
		checkValue(testName, "aluOp", int'(expectedOp), int'(aluOp));
		expectState(testName, writeState);
		checkValue(testName, "regWrite", 1, int'(regWrite));
		checkValue(testName, "regDst", int'(dstRt), int'(regDst));
		expectState(testName, Fetch);
	endtask

	task automatic testImmediates();
		immediateCase("addi", opAddi, Addi1, Addi2, aluAdd);
		immediateCase("addiu", opAddiu, Addi1, Addi2, aluAdd);
		immediateCase("xori", opXori, Xori1, Xori2, aluXor);
	endtask

	task automatic loadSequence(input string testName, input logic [opWidth-1:0] opcode,
		input loadSizeT expectedSize);
		fetchAndDecode(testName, opcode, randomFunct());
		expectState(testName, Load);
		checkValue(testName, "mdrInSize", int'(expectedSize), int'(mdrInSize));
		expectState(testName, Load1);
		checkValue(testName, "iOrD", int'(addrAluOut), int'(iOrD));
		expectState(testName, Load2);
		expectState(testName, Load3);
		checkValue(testName, "mdrLoad", 1, int'(mdrLoad));
		expectState(testName, Load4);
		checkValue(testName, "regWrite", 1, int'(regWrite));
		checkValue(testName, "memToReg", int'(memMdr), int'(memToReg));
		checkValue(testName, "regDst", int'(dstRt), int'(regDst));
		expectState(testName, Fetch);
	endtask

	task automatic testLoadsAndStore();
		loadSequence("lb", opLb, sizeByte);    // Differs from the reset width
		loadSequence("lh", opLh, sizeHalf);
		loadSequence("lw", opLw, sizeWord);
		fetchAndDecode("sw", opSw, randomFunct());
		expectState("sw", Sw);
		checkValue("sw", "memWrite in Sw", 0, int'(memWrite));
		expectState("sw", Sw1);
		checkValue("sw", "memWrite in Sw1", 1, int'(memWrite));
		expectState("sw", Fetch);
	endtask

	task automatic branchCase(input string testName, input logic [opWidth-1:0] opcode,
		input stateT branchState, input logic zero, input logic expectedPcWrite);
		nextZero = zero;
		fetchAndDecode(testName, opcode, randomFunct());
		expectState(testName, branchState);
		checkValue(testName, "pcWrite", int'(expectedPcWrite), int'(pcWrite));
		checkValue(testName, "aluOp", int'(aluSub), int'(aluOp));
		expectState(testName, Fetch);
	endtask

	task automatic compareCase(input string testName, input logic [opWidth-1:0] opcode,
		input logic [opWidth-1:0] fn, input stateT firstState, input logic less,
		input memToRegT expectedSel);
		nextLess = less;
		fetchAndDecode(testName, opcode, fn);
		expectState(testName, firstState);
		expectState(testName, SltCont);
		checkValue(testName, "regWrite", 1, int'(regWrite));
		checkValue(testName, "memToReg", int'(expectedSel), int'(memToReg));
		expectState(testName, Fetch);
	endtask

	task automatic testBranchesAndCompares();
		branchCase("beqTaken", opBeq, Beq, 1'b1, 1'b1);
		branchCase("beqNotTaken", opBeq, Beq, 1'b0, 1'b0);
		branchCase("bneNotTaken", opBne, Bne, 1'b1, 1'b0);
		branchCase("bneTaken", opBne, Bne, 1'b0, 1'b1);
		compareCase("sltLess", opRtype, fnSlt, Slt, 1'b1, memOne);
		compareCase("sltiNotLess", opSlti, randomFunct(), Slti, 1'b0, memZero);
		nextZero = 1'b0;
	endtask

	// Overflow in the arithmetic state diverts to the trap sequence
	task automatic overflowCase(input string testName, input logic [opWidth-1:0] opcode,
		input logic [opWidth-1:0] fn, input stateT arithState);
		fetchAndDecode(testName, opcode, fn);
		expectState(testName, arithState);
		expectState(testName, Ovf);
		checkValue(testName, "iOrD", int'(addrOvf), int'(iOrD));
		checkValue(testName, "epcWrite", 1, int'(epcWrite));
		expectState(testName, Ovf1);
		expectState(testName, Ovf2);
		checkValue(testName, "pcWrite", 1, int'(pcWrite));
		checkValue(testName, "epcSelect", int'(epcVector), int'(epcSelect));
		expectState(testName, Fetch);
	endtask

	task automatic testExceptions();
		fetchAndDecode("invalidOp", opInvalid, randomFunct());
		expectState("invalidOp", OpExc);
		checkValue("invalidOp", "iOrD", int'(addrOpExc), int'(iOrD));
		checkValue("invalidOp", "epcWrite", 1, int'(epcWrite));
		expectState("invalidOp", OpExc1);
		expectState("invalidOp", OpExc2);
		checkValue("invalidOp", "pcWrite", 1, int'(pcWrite));
		checkValue("invalidOp", "epcSelect", int'(epcVector), int'(epcSelect));
		expectState("invalidOp", Fetch);
		nextOvf = 1'b1;
		overflowCase("ovfAdd", opRtype, fnAdd, Rtype);
		overflowCase("ovfAddi", opAddi, randomFunct(), Addi1);
		runInstruction("exemptAddu", opRtype, fnAddu, Rtype, 2);
		runInstruction("exemptSubu", opRtype, fnSubu, Rtype, 2);
		runInstruction("exemptAddiu", opAddiu, randomFunct(), Addi1, 2);
		nextOvf = 1'b0;
		fetchAndDecode("rte", opRte, randomFunct());
		expectState("rte", Rte);
		checkValue("rte", "pcWrite", 1, int'(pcWrite));
		checkValue("rte", "epcSelect", int'(epcReturn), int'(epcSelect));
		expectState("rte", Fetch);
	endtask

	task automatic testBreak();
		fetchAndDecode("break", opLw, randomFunct());
		@(posedge Clk);
		breakReq <= 1'b1;    // One-cycle pulse
		expectState("break", Load);
		@(posedge Clk);
		breakReq <= 1'b0;
		repeat (3) begin
			expectState("break", Brk);
			checkWritesIdle("break");
			checkValue("break", "aluOutLoad", 0, int'(aluOutLoad));
		end
		applyReset(2);
		runInstruction("afterBreak", opJ, randomFunct(), J, 1);
	endtask

	initial begin
		Reset        = 1'b1;
		op           = opRtype;
		funct        = '0;
		breakReq     = 1'b0;
		overflowFlag = 1'b0;
		zeroFlag     = 1'b0;
		lessFlag     = 1'b0;
		seed         = 32'h58c93a2d;
		applyReset(5);
		testFetchSequence();
		testRtype();
		testJumps();
		testImmediates();
		testLoadsAndStore();
		testBranchesAndCompares();
		testExceptions();
		testBreak();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/controlUnit_properties.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit_properties (
	input logic              Clk,
	input logic              Reset,
	input controlPkg::stateT state,
	input logic              memWrite,
	input logic              regWrite,
	input logic              irWrite
);

	import controlPkg::*;

	// Memory and register file never written in the same cycle
	noDoubleWrite: assert property (@(posedge Clk) disable iff (Reset)
		!(memWrite && regWrite))
		else $error("memWrite and regWrite high in the same cycle");

	irOnlyInF2: assert property (@(posedge Clk) disable iff (Reset)
		irWrite |-> (state == F2))
		else $error("irWrite high outside F2");

	// Only Reset leaves Brk
	brkHolds: assert property (@(posedge Clk) disable iff (Reset)
		($past(state) == Brk) |-> (state == Brk))
		else $error("state left Brk without Reset");

endmodule

bind controlUnit controlUnit_properties controlUnitProps_i (
	.Clk      (Clk),
	.Reset    (Reset),
	.state    (state),
	.memWrite (memWrite),
	.regWrite (regWrite),
	.irWrite  (irWrite)
);

`default_nettype wire
